/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    ////////////////////
    // alu opcodes
    ////////////////////

    localparam int OP_W = 3;

    typedef enum logic [OP_W-1:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        SLL  = 3'd5,   // shift by low bits of src b
        SRL  = 3'd6,   // logical, zero fill
        ADDI = 3'd7    // rs1 plus sign extended imm
    } op_e;

    ////////////////////
    // widths and defaults
    ////////////////////

    localparam int IMM_W = 16;   // only ADDI reads it

    localparam int DEF_XLEN      = 32;
    localparam int DEF_REG_COUNT = 32;

    // register index width for a given register count
    function automatic int reg_idx_w(input int reg_count);
        int w;
        w = $clog2(reg_count);
        if (w < 1) begin
            w = 1;
        end
        return w;
    endfunction

endpackage

`default_nettype wire

/* src/dual_issue_core.sv */
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core
    import core_pkg::*;
#(
    parameter int  XLEN      = DEF_XLEN,
    parameter int  REG_COUNT = DEF_REG_COUNT,
    localparam int RW        = reg_idx_w(REG_COUNT)
) (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_valid,
    input  logic [1:0]       i_slot_valid,
    input  op_e              i_slot_op  [2],
    input  logic [RW-1:0]    i_slot_rd  [2],
    input  logic [RW-1:0]    i_slot_rs1 [2],
    input  logic [RW-1:0]    i_slot_rs2 [2],
    input  logic [IMM_W-1:0] i_slot_imm [2],
    output logic             o_ready,
    output logic [1:0]       o_wb_we,          // one per lane
    output logic [RW-1:0]    o_wb_addr [2],
    output logic [XLEN-1:0]  o_wb_data [2]
);

    logic [RW-1:0]   rf_raddr [4];
    logic [XLEN-1:0] rf_rdata [4];

    lane_op_if #(.REG_COUNT(REG_COUNT)) lane0_if ();
    lane_op_if #(.REG_COUNT(REG_COUNT)) lane1_if ();

    issue_dispatch #(
        .REG_COUNT (REG_COUNT)
    ) issue_dispatch_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_slot_valid (i_slot_valid),
        .i_slot_op    (i_slot_op),
        .i_slot_rd    (i_slot_rd),
        .i_slot_rs1   (i_slot_rs1),
        .i_slot_rs2   (i_slot_rs2),
        .i_slot_imm   (i_slot_imm),
        .o_ready      (o_ready),
        .lane0        (lane0_if.issue),
        .lane1        (lane1_if.issue)
    );

    // result registers feed both the file and the write-back outputs
    exec_pair #(
        .XLEN      (XLEN),
        .REG_COUNT (REG_COUNT)
    ) exec_pair_inst (
        .clk     (clk),
        .i_reset (i_reset),
        .lane0   (lane0_if.exec),
        .lane1   (lane1_if.exec),
        .o_raddr (rf_raddr),
        .i_rdata (rf_rdata),
        .o_we    (o_wb_we),
        .o_waddr (o_wb_addr),
        .o_wdata (o_wb_data)
    );

    reg_file #(
        .XLEN      (XLEN),
        .REG_COUNT (REG_COUNT)
    ) reg_file_inst (
        .clk     (clk),
        .i_reset (i_reset),
        .i_raddr (rf_raddr),
        .o_rdata (rf_rdata),
        .i_we    (o_wb_we),
        .i_waddr (o_wb_addr),
        .i_wdata (o_wb_data)
    );

endmodule

`default_nettype wire

/* src/exec_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_lane
    import core_pkg::*;
#(
    parameter int  XLEN      = DEF_XLEN,
    parameter int  REG_COUNT = DEF_REG_COUNT,
    localparam int RW        = reg_idx_w(REG_COUNT),
    localparam int SH_W      = $clog2(XLEN)
) (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_valid,
    input  op_e              i_op,
    input  logic [RW-1:0]    i_rd,
    input  logic [XLEN-1:0]  i_src_a,
    input  logic [XLEN-1:0]  i_src_b,
    input  logic [IMM_W-1:0] i_imm,
    output logic             o_we,
    output logic [RW-1:0]    o_waddr,
    output logic [XLEN-1:0]  o_wdata
);

    logic [XLEN-1:0] imm_ext;
    logic [SH_W-1:0] shamt;
    logic [XLEN-1:0] result;

    assign imm_ext = {{(XLEN-IMM_W){i_imm[IMM_W-1]}}, i_imm};
    assign shamt   = i_src_b[SH_W-1:0];

    always_comb begin
        case (i_op)
            ADD:     result = i_src_a + i_src_b;
            SUB:     result = i_src_a - i_src_b;
            AND:     result = i_src_a & i_src_b;
            OR:      result = i_src_a | i_src_b;
            XOR:     result = i_src_a ^ i_src_b;
            SLL:     result = i_src_a << shamt;
            SRL:     result = i_src_a >> shamt;
            ADDI:    result = i_src_a + imm_ext;
            default: result = '0;
        endcase
    end

    ////////////////////
    // result register, write-back in the cycle after issue

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_we <= 1'b0;
        end else begin
            o_we <= i_valid && (i_rd != '0);   // r0 writes dropped here
        end
    end

    always_ff @(posedge clk) begin
        o_waddr <= i_rd;
        o_wdata <= result;
    end

endmodule

`default_nettype wire

/* src/exec_pair.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pair
    import core_pkg::*;
#(
    parameter int  XLEN      = DEF_XLEN,
    parameter int  REG_COUNT = DEF_REG_COUNT,
    localparam int RW        = reg_idx_w(REG_COUNT)
) (
    input  logic            clk,
    input  logic            i_reset,
    lane_op_if.exec         lane0,
    lane_op_if.exec         lane1,
    output logic [RW-1:0]   o_raddr [4],   // a0, b0, a1, b1
    input  logic [XLEN-1:0] i_rdata [4],
    output logic [1:0]      o_we,
    output logic [RW-1:0]   o_waddr [2],
    output logic [XLEN-1:0] o_wdata [2]
);

    logic [XLEN-1:0] src [4];   // operands after bypass

    assign o_raddr[0] = lane0.rs1;
    assign o_raddr[1] = lane0.rs2;
    assign o_raddr[2] = lane1.rs1;
    assign o_raddr[3] = lane1.rs2;

    ////////////////////
    // operand bypass
    // the write-back of this cycle lands in the file only at the edge,
    // so a reader in the same cycle takes it from the result registers

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (o_we[1] && (o_waddr[1] == o_raddr[i])) begin
                src[i] = o_wdata[1];   // lane 1 holds the younger result
            end else if (o_we[0] && (o_waddr[0] == o_raddr[i])) begin
                src[i] = o_wdata[0];
            end else begin
                src[i] = i_rdata[i];
            end
        end
    end

    exec_lane #(
        .XLEN      (XLEN),
        .REG_COUNT (REG_COUNT)
    ) lane0_inst (
        .clk     (clk),
        .i_reset (i_reset),
        .i_valid (lane0.valid),
        .i_op    (lane0.op),
        .i_rd    (lane0.rd),
        .i_src_a (src[0]),
        .i_src_b (src[1]),
        .i_imm   (lane0.imm),
        .o_we    (o_we[0]),
        .o_waddr (o_waddr[0]),
        .o_wdata (o_wdata[0])
    );

    exec_lane #(
        .XLEN      (XLEN),
        .REG_COUNT (REG_COUNT)
    ) lane1_inst (
        .clk     (clk),
        .i_reset (i_reset),
        .i_valid (lane1.valid),
        .i_op    (lane1.op),
        .i_rd    (lane1.rd),
        .i_src_a (src[2]),
        .i_src_b (src[3]),
        .i_imm   (lane1.imm),
        .o_we    (o_we[1]),
        .o_waddr (o_waddr[1]),
        .o_wdata (o_wdata[1])
    );

endmodule

`default_nettype wire

/* src/issue_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch
    import core_pkg::*;
#(
    parameter int  REG_COUNT = DEF_REG_COUNT,
    localparam int RW        = reg_idx_w(REG_COUNT)
) (
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_valid,
    input  logic [1:0]       i_slot_valid,   // bit 0 is the older slot
    input  op_e              i_slot_op  [2],
    input  logic [RW-1:0]    i_slot_rd  [2],
    input  logic [RW-1:0]    i_slot_rs1 [2],
    input  logic [RW-1:0]    i_slot_rs2 [2],
    input  logic [IMM_W-1:0] i_slot_imm [2],
    output logic             o_ready,
    lane_op_if.issue         lane0,
    lane_op_if.issue         lane1
);

    typedef enum logic {
        ISSUE_PAIR,     // held slots go out together
        ISSUE_SECOND    // slot 0 goes now, slot 1 next cycle
    } split_e;

    split_e           state;
    logic [1:0]       pend;          // held slots not yet issued
    op_e              hold_op  [2];
    logic [RW-1:0]    hold_rd  [2];
    logic [RW-1:0]    hold_rs1 [2];
    logic [RW-1:0]    hold_rs2 [2];
    logic [IMM_W-1:0] hold_imm [2];

    logic accept;
    logic rs_hit;
    logic need_split;

    assign o_ready = (state == ISSUE_PAIR);
    assign accept  = i_valid && o_ready;

    // slot 1 reads what slot 0 writes, ADDI has no rs2
    assign rs_hit = (i_slot_rs1[1] == i_slot_rd[0]) ||
                    ((i_slot_op[1] != ADDI) && (i_slot_rs2[1] == i_slot_rd[0]));

    assign need_split = (i_slot_valid == 2'b11) && (i_slot_rd[0] != '0) && rs_hit;

    ////////////////////
    // split control

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= ISSUE_PAIR;
            pend  <= 2'b00;
        end else if (state == ISSUE_SECOND) begin
            // slot 0 left this cycle, slot 1 follows alone
            state <= ISSUE_PAIR;
            pend  <= 2'b10;
        end else if (accept) begin
            state <= need_split ? ISSUE_SECOND : ISSUE_PAIR;
            pend  <= i_slot_valid;
        end else begin
            pend  <= 2'b00;   // dispatch register drained
        end
    end

    // pair payload, loaded only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < 2; i++) begin
                hold_op[i]  <= i_slot_op[i];
                hold_rd[i]  <= i_slot_rd[i];
                hold_rs1[i] <= i_slot_rs1[i];
                hold_rs2[i] <= i_slot_rs2[i];
                hold_imm[i] <= i_slot_imm[i];
            end
        end
    end

    ////////////////////
    // issue to the lanes

    assign lane0.valid = pend[0];
    assign lane0.op    = hold_op[0];
    assign lane0.rd    = hold_rd[0];
    assign lane0.rs1   = hold_rs1[0];
    assign lane0.rs2   = hold_rs2[0];
    assign lane0.imm   = hold_imm[0];

    // held back while slot 0 of a split pair goes out
    assign lane1.valid = pend[1] && (state == ISSUE_PAIR);
    assign lane1.op    = hold_op[1];
    assign lane1.rd    = hold_rd[1];
    assign lane1.rs1   = hold_rs1[1];
    assign lane1.rs2   = hold_rs2[1];
    assign lane1.imm   = hold_imm[1];

endmodule

`default_nettype wire

/* src/lane_op_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one issued instruction, qualified by valid in the cycle it is driven
interface lane_op_if
    import core_pkg::*;
#(
    parameter int  REG_COUNT = DEF_REG_COUNT,
    localparam int RW        = reg_idx_w(REG_COUNT)
);

    logic             valid;
    op_e              op;
    logic [RW-1:0]    rd;
    logic [RW-1:0]    rs1;
    logic [RW-1:0]    rs2;
    logic [IMM_W-1:0] imm;

    modport issue (
        output valid, op, rd, rs1, rs2, imm
    );

    modport exec (
        input valid, op, rd, rs1, rs2, imm
    );

endinterface

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import core_pkg::*;
#(
    parameter int  XLEN      = DEF_XLEN,
    parameter int  REG_COUNT = DEF_REG_COUNT,
    localparam int RW        = reg_idx_w(REG_COUNT)
) (
    input  logic            clk,
    input  logic            i_reset,
    input  logic [RW-1:0]   i_raddr [4],
    output logic [XLEN-1:0] o_rdata [4],
    input  logic [1:0]      i_we,
    input  logic [RW-1:0]   i_waddr [2],
    input  logic [XLEN-1:0] i_wdata [2]
);

    logic [XLEN-1:0] regs [REG_COUNT];

    ////////////////////
    // write ports

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int r = 0; r < REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // port 1 last, so lane 1 wins a shared address
            for (int w = 0; w < 2; w++) begin
                if (i_we[w]) begin
                    regs[i_waddr[w]] <= i_wdata[w];
                end
            end
        end
    end

    // read ports, r0 reads as zero
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (i_raddr[p] == '0) begin
                o_rdata[p] = '0;
            end else begin
                o_rdata[p] = regs[i_raddr[p]];
            end
        end
    end

endmodule

`default_nettype wire

/* tb.f */
src/core_pkg.sv
src/lane_op_if.sv
src/issue_dispatch.sv
src/exec_lane.sv
src/exec_pair.sv
src/reg_file.sv
src/dual_issue_core.sv
test/tb_core.sv

/* test/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core
    import core_pkg::*;
();

    localparam int XLEN      = DEF_XLEN;
    localparam int REG_COUNT = DEF_REG_COUNT;
    localparam int RW        = reg_idx_w(REG_COUNT);
    localparam int NUM_PAIRS = 400;
    localparam int CYC_LIMIT = 4 * NUM_PAIRS + 20;
    localparam int SCHED_LEN = CYC_LIMIT + 4;   // room for the split slot at c + 3

    logic             clk;
    logic             i_reset;
    logic             i_valid;
    logic [1:0]       i_slot_valid;
    op_e              i_slot_op  [2];
    logic [RW-1:0]    i_slot_rd  [2];
    logic [RW-1:0]    i_slot_rs1 [2];
    logic [RW-1:0]    i_slot_rs2 [2];
    logic [IMM_W-1:0] i_slot_imm [2];
    logic             o_ready;
    logic [1:0]       o_wb_we;
    logic [RW-1:0]    o_wb_addr [2];
    logic [XLEN-1:0]  o_wb_data [2];

    integer seed;
    int     cycle;
    int     accepted;
    int     split_count;
    int     r0_count;
    int     waw_count;
    bit     model_ready;
    bit     split_now;

    logic [XLEN-1:0] shadow [REG_COUNT];   // in-order register state

    // expected write-back of each cycle by cycle count
    bit   [1:0]      exp_we   [SCHED_LEN];
    logic [RW-1:0]   exp_addr [SCHED_LEN][2];
    logic [XLEN-1:0] exp_data [SCHED_LEN][2];

    dual_issue_core #(
        .XLEN      (XLEN),
        .REG_COUNT (REG_COUNT)
    ) dut (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_slot_valid (i_slot_valid),
        .i_slot_op    (i_slot_op),
        .i_slot_rd    (i_slot_rd),
        .i_slot_rs1   (i_slot_rs1),
        .i_slot_rs2   (i_slot_rs2),
        .i_slot_imm   (i_slot_imm),
        .o_ready      (o_ready),
        .o_wb_we      (o_wb_we),
        .o_wb_addr    (o_wb_addr),
        .o_wb_data    (o_wb_data)
    );

    always #10 clk = ~clk;

    // cycle count and run limit
    always @(posedge clk) begin
        if (cycle >= CYC_LIMIT) begin
            $display("Timeout: test did not end within %0d cycles", CYC_LIMIT);
            $display("Finished with errors");
            $fatal(1, "cycle limit reached");
        end else begin
            cycle <= cycle + 1;
        end
    end

    ////////////////////
    // reference model

    function automatic logic [XLEN-1:0] alu_model(input op_e op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b,
                                                  input logic [IMM_W-1:0] imm);
        logic [XLEN-1:0] imm_sx;
        imm_sx = $signed(imm);   // sign extend to XLEN
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[$clog2(XLEN)-1:0];
            SRL:     return a >> b[$clog2(XLEN)-1:0];
            default: return a + imm_sx;   // ADDI
        endcase
    endfunction

    // split when slot 1 reads slot 0's destination (ADDI has no rs2)
    function automatic bit must_split(input logic [1:0] sv, input op_e op1,
                                      input logic [RW-1:0] rd0, input logic [RW-1:0] rs1_1,
                                      input logic [RW-1:0] rs2_1);
        bit reads;
        reads = (rs1_1 == rd0) || ((op1 != ADDI) && (rs2_1 == rd0));
        return (sv == 2'b11) && (rd0 != '0) && reads;
    endfunction

    // runs the accepted pair in order and books its write-backs
    task automatic apply_pair(input int c, output bit split);
        logic [XLEN-1:0] res;
        int              when;
        split = must_split(i_slot_valid, i_slot_op[1], i_slot_rd[0], i_slot_rs1[1],
                           i_slot_rs2[1]);
        for (int s = 0; s < 2; s++) begin
            if (i_slot_valid[s]) begin
                res  = alu_model(i_slot_op[s], shadow[i_slot_rs1[s]], shadow[i_slot_rs2[s]],
                                 i_slot_imm[s]);
                when = (s == 1 && split) ? c + 3 : c + 2;
                if (i_slot_rd[s] != '0) begin
                    exp_we[when][s]   = 1'b1;
                    exp_addr[when][s] = i_slot_rd[s];
                    exp_data[when][s] = res;
                    shadow[i_slot_rd[s]] = res;
                end else begin
                    r0_count++;   // dropped write
                end
            end
        end
        if (split) begin
            split_count++;
        end
        // both lanes write the same register at the same edge
        if (!split && (i_slot_valid == 2'b11) && (i_slot_rd[0] == i_slot_rd[1]) &&
            (i_slot_rd[0] != '0)) begin
            waw_count++;
        end
    endtask

    ////////////////////
    // checking

    task automatic check_value(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_cycle();
        check_value(XLEN'(o_ready), XLEN'(model_ready), "o_ready");
        for (int l = 0; l < 2; l++) begin
            check_value(XLEN'(o_wb_we[l]), XLEN'(exp_we[cycle][l]),
                        $sformatf("lane %0d write enable", l));
            if (exp_we[cycle][l]) begin
                check_value(XLEN'(o_wb_addr[l]), XLEN'(exp_addr[cycle][l]),
                            $sformatf("lane %0d write address", l));
                check_value(o_wb_data[l], exp_data[cycle][l],
                            $sformatf("lane %0d write data", l));
            end
        end
    endtask

    // register numbers kept to 0..7 so pairs collide often
    task automatic drive_random();
        int pick;
        i_valid = (($random(seed) & 7) != 0);
        pick    = $random(seed) & 3;
        i_slot_valid = (pick == 0) ? 2'($random(seed)) : 2'b11;
        for (int s = 0; s < 2; s++) begin
            i_slot_op[s]  = op_e'(3'($random(seed)));
            i_slot_rd[s]  = RW'($random(seed) & 7);
            i_slot_rs1[s] = RW'($random(seed) & 7);
            i_slot_rs2[s] = RW'($random(seed) & 7);
            i_slot_imm[s] = IMM_W'($random(seed));
        end
    endtask

    ////////////////////
    // main sequence

    initial begin
        seed         = 91360;
        clk          = 1'b0;
        i_reset      = 1'b1;
        i_valid      = 1'b0;
        i_slot_valid = 2'b00;
        for (int s = 0; s < 2; s++) begin
            i_slot_op[s]  = ADD;
            i_slot_rd[s]  = '0;
            i_slot_rs1[s] = '0;
            i_slot_rs2[s] = '0;
            i_slot_imm[s] = '0;
        end
        cycle       = 0;
        accepted    = 0;
        split_count = 0;
        r0_count    = 0;
        waw_count   = 0;
        model_ready = 1'b1;
        for (int r = 0; r < REG_COUNT; r++) begin
            shadow[r] = '0;
        end

        repeat (4) @(negedge clk);
        i_reset = 1'b0;
        check_value(XLEN'(o_ready), XLEN'(1), "o_ready after reset");
        check_value(XLEN'(o_wb_we), XLEN'(0), "write enables after reset");

        while (accepted < NUM_PAIRS) begin
            check_cycle();
            drive_random();
            if (i_valid && model_ready) begin
                apply_pair(cycle, split_now);
                accepted++;
                model_ready = !split_now;   // one dead cycle after a split
            end else begin
                model_ready = 1'b1;
            end
            @(negedge clk);
        end

        // drain the last write-backs
        i_valid = 1'b0;
        repeat (4) begin
            check_cycle();
            model_ready = 1'b1;
            @(negedge clk);
        end

        $display("pairs %0d, splits %0d, r0 writes %0d, same rd pairs %0d",
                 accepted, split_count, r0_count, waw_count);
        if (split_count == 0 || r0_count == 0 || waw_count == 0) begin
            $display("Stimulus missed a dependent pair, an r0 write or a shared rd pair");
            $display("Finished with errors");
            $fatal(1, "incomplete stimulus");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
